/* resp_capture_if.sv */
`timescale 1ns/1ns

// a response that has been latched and matched against its tag entry.
interface resp_capture_if import response_pkg::*; #(
  parameter int CU_ID_WIDTH = 8
);

  logic                       valid;
  logic [TAG_WIDTH-1:0]       tag;
  cmd_type_t                  cmd_type;
  logic [CU_ID_WIDTH-1:0]     cu_id;
  logic [RESP_CODE_WIDTH-1:0] code;
  logic                       parity_error;

  // valid qualifies the other fields for a single cycle.
  modport source (
    output valid, tag, cmd_type, cu_id, code, parity_error
  );

  modport sink (
    input valid, tag, cmd_type, cu_id, code, parity_error
  );

endinterface

/* response_capture.sv */
`timescale 1ns/1ns

module response_capture import response_pkg::*; #(
  parameter int CU_ID_WIDTH = 8
) (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       enabled,
  input  logic                       resp_valid,
  input  logic [TAG_WIDTH-1:0]       resp_tag,
  input  logic                       resp_tag_parity,
  input  logic [RESP_CODE_WIDTH-1:0] resp_code,
  input  logic                       cmd_valid,
  input  logic [TAG_WIDTH-1:0]       cmd_tag,
  input  cmd_type_t                  cmd_type,
  input  logic [CU_ID_WIDTH-1:0]     cmd_cu_id,
  resp_capture_if.source             captured
);

  logic                   accept;
  logic                   parity_ok;
  cmd_type_t              lookup_type;
  logic [CU_ID_WIDTH-1:0] lookup_cu_id;

  tag_table #(
    .CU_ID_WIDTH(CU_ID_WIDTH)
  ) tag_table_i (
    .clock      (clock),
    .rstn       (rstn),
    .write      (cmd_valid),
    .write_tag  (cmd_tag),
    .write_type (cmd_type),
    .write_cu_id(cmd_cu_id),
    .read_tag   (resp_tag),
    .read_type  (lookup_type),
    .read_cu_id (lookup_cu_id)
  );

  assign accept = enabled && resp_valid;

  // the tag and its parity bit together must hold an odd number of ones.
  assign parity_ok = ^{resp_tag, resp_tag_parity};

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      captured.valid <= 1'b0;
    end else begin
      captured.valid <= accept;
    end
  end

  // payload only moves when a response is taken, valid tells the rest apart.
  always_ff @(posedge clock) begin
    if (accept) begin
      captured.tag          <= resp_tag;
      captured.cmd_type     <= lookup_type;
      captured.cu_id        <= lookup_cu_id;
      captured.code         <= resp_code;
      captured.parity_error <= !parity_ok;
    end
  end

endmodule

/* response_control.sv */
`timescale 1ns/1ns

module response_control import response_pkg::*; #(
  parameter int CU_ID_WIDTH = 8
) (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       error_report_enable,
  resp_capture_if.sink               captured,
  output logic                       read_response,
  output logic                       write_response,
  output logic                       wed_response,
  output logic                       restart_response,
  output logic                       out_valid,
  output logic [CU_ID_WIDTH-1:0]     out_cu_id,
  output cmd_type_t                  out_cmd_type,
  output logic [RESP_CODE_WIDTH-1:0] out_code,
  output logic [ERR_WIDTH-1:0]       response_error,
  output logic                       err_valid,
  output logic [ERR_WIDTH-1:0]       err_vector
);

  logic [ERR_WIDTH-1:0] decoded;

  // map the host code onto its flag, parity sits in the top bit.
  always_comb begin
    decoded = '0;
    case (captured.code)
      RESP_AERROR:  decoded[ERR_AERROR]  = 1'b1;
      RESP_DERROR:  decoded[ERR_DERROR]  = 1'b1;
      RESP_FAULT:   decoded[ERR_FAULT]   = 1'b1;
      RESP_FAILED:  decoded[ERR_FAILED]  = 1'b1;
      RESP_PAGED:   decoded[ERR_PAGED]   = 1'b1;
      RESP_FLUSHED: decoded[ERR_FLUSHED] = 1'b1;
      // done, lock and reservation misses are not errors.
      RESP_DONE, RESP_NLOCK, RESP_NRES: decoded[ERR_TAG_PARITY-1:0] = '0;
      default:      decoded[ERR_TAG_PARITY-1:0] = '0;
    endcase
    decoded[ERR_TAG_PARITY] = captured.parity_error;
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      read_response    <= 1'b0;
      write_response   <= 1'b0;
      wed_response     <= 1'b0;
      restart_response <= 1'b0;
      out_valid        <= 1'b0;
      out_cu_id        <= '0;
      out_cmd_type     <= CMD_NONE;
      out_code         <= '0;
      err_vector       <= '0;
    end else begin
      // an unused tag routes to none of the four.
      read_response    <= captured.valid && (captured.cmd_type == CMD_READ);
      write_response   <= captured.valid && (captured.cmd_type == CMD_WRITE);
      wed_response     <= captured.valid && (captured.cmd_type == CMD_WED);
      restart_response <= captured.valid && (captured.cmd_type == CMD_RESTART);
      out_valid        <= captured.valid;
      out_cu_id        <= captured.valid ? captured.cu_id : '0;
      out_cmd_type     <= captured.valid ? captured.cmd_type : CMD_NONE;
      out_code         <= captured.valid ? captured.code : '0;
      err_vector       <= captured.valid ? decoded : '0;
    end
  end

  assign err_valid = out_valid;

  // the status block always gets the full vector, the port is masked.
  assign response_error = error_report_enable ? err_vector : '0;

endmodule

/* response_path_top.sv */
`timescale 1ns/1ns

module response_path_top import response_pkg::*; #(
  parameter int CU_ID_WIDTH = 8
) (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       cmd_valid,
  input  logic [TAG_WIDTH-1:0]       cmd_tag,
  input  cmd_type_t                  cmd_type,
  input  logic [CU_ID_WIDTH-1:0]     cmd_cu_id,
  input  logic                       resp_valid,
  input  logic [TAG_WIDTH-1:0]       resp_tag,
  input  logic                       resp_tag_parity,
  input  logic [RESP_CODE_WIDTH-1:0] resp_code,
  input  logic [ADDR_WIDTH-1:0]      paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [DATA_WIDTH-1:0]      pwdata,
  output logic [DATA_WIDTH-1:0]      prdata,
  output logic                       pready,
  output logic                       pslverr,
  output logic                       read_response,
  output logic                       write_response,
  output logic                       wed_response,
  output logic                       restart_response,
  output logic                       out_valid,
  output logic [CU_ID_WIDTH-1:0]     out_cu_id,
  output cmd_type_t                  out_cmd_type,
  output logic [RESP_CODE_WIDTH-1:0] out_code,
  output logic [ERR_WIDTH-1:0]       response_error
);

  logic                 enabled;
  logic                 error_report_enable;
  logic                 err_valid;
  logic [ERR_WIDTH-1:0] err_vector;

  resp_capture_if #(.CU_ID_WIDTH(CU_ID_WIDTH)) captured ();

  response_capture #(
    .CU_ID_WIDTH(CU_ID_WIDTH)
  ) response_capture_i (
    .clock          (clock),
    .rstn           (rstn),
    .enabled        (enabled),
    .resp_valid     (resp_valid),
    .resp_tag       (resp_tag),
    .resp_tag_parity(resp_tag_parity),
    .resp_code      (resp_code),
    .cmd_valid      (cmd_valid),
    .cmd_tag        (cmd_tag),
    .cmd_type       (cmd_type),
    .cmd_cu_id      (cmd_cu_id),
    .captured       (captured.source)
  );

  response_control #(
    .CU_ID_WIDTH(CU_ID_WIDTH)
  ) response_control_i (
    .clock              (clock),
    .rstn               (rstn),
    .error_report_enable(error_report_enable),
    .captured           (captured.sink),
    .read_response      (read_response),
    .write_response     (write_response),
    .wed_response       (wed_response),
    .restart_response   (restart_response),
    .out_valid          (out_valid),
    .out_cu_id          (out_cu_id),
    .out_cmd_type       (out_cmd_type),
    .out_code           (out_code),
    .response_error     (response_error),
    .err_valid          (err_valid),
    .err_vector         (err_vector)
  );

  response_status_apb response_status_apb_i (
    .clock              (clock),
    .rstn               (rstn),
    .paddr              (paddr),
    .psel               (psel),
    .penable            (penable),
    .pwrite             (pwrite),
    .pwdata             (pwdata),
    .err_valid          (err_valid),
    .err_vector         (err_vector),
    .prdata             (prdata),
    .pready             (pready),
    .pslverr            (pslverr),
    .enabled            (enabled),
    .error_report_enable(error_report_enable)
  );

endmodule

/* response_pkg.sv */
package response_pkg;

  // kind of command that was issued under a tag.
  typedef enum logic [2:0] {
    CMD_NONE    = 3'd0,
    CMD_READ    = 3'd1,
    CMD_WRITE   = 3'd2,
    CMD_WED     = 3'd3,
    CMD_RESTART = 3'd4
  } cmd_type_t;

  localparam int TAG_WIDTH       = 8;
  localparam int TAG_DEPTH       = 1 << TAG_WIDTH;
  localparam int RESP_CODE_WIDTH = 8;
  localparam int ERR_WIDTH       = 7;
  localparam int ADDR_WIDTH      = 12;
  localparam int DATA_WIDTH      = 32;
  localparam int COUNT_WIDTH     = 16;

  // response codes returned by the host on the link.
  localparam logic [RESP_CODE_WIDTH-1:0] RESP_DONE    = 8'h00;
  localparam logic [RESP_CODE_WIDTH-1:0] RESP_AERROR  = 8'h01;
  localparam logic [RESP_CODE_WIDTH-1:0] RESP_DERROR  = 8'h03;
  localparam logic [RESP_CODE_WIDTH-1:0] RESP_NLOCK   = 8'h04;
  localparam logic [RESP_CODE_WIDTH-1:0] RESP_NRES    = 8'h05;
  localparam logic [RESP_CODE_WIDTH-1:0] RESP_FLUSHED = 8'h06;
  localparam logic [RESP_CODE_WIDTH-1:0] RESP_FAULT   = 8'h07;
  localparam logic [RESP_CODE_WIDTH-1:0] RESP_FAILED  = 8'h08;
  localparam logic [RESP_CODE_WIDTH-1:0] RESP_PAGED   = 8'h0A;

  // bit positions inside the error vector.
  localparam int ERR_TAG_PARITY = 6;
  localparam int ERR_AERROR     = 5;
  localparam int ERR_DERROR     = 4;
  localparam int ERR_FAULT      = 3;
  localparam int ERR_FAILED     = 2;
  localparam int ERR_PAGED      = 1;
  localparam int ERR_FLUSHED    = 0;

  // byte offsets of the status registers.
  localparam logic [ADDR_WIDTH-1:0] REG_CONTROL    = 12'h000;
  localparam logic [ADDR_WIDTH-1:0] REG_STATUS     = 12'h004;
  localparam logic [ADDR_WIDTH-1:0] REG_RESP_COUNT = 12'h008;
  localparam logic [ADDR_WIDTH-1:0] REG_ERR_COUNT  = 12'h00C;

endpackage

/* response_status_apb.sv */
`timescale 1ns/1ns

module response_status_apb import response_pkg::*; (
  input  logic                  clock,
  input  logic                  rstn,
  input  logic [ADDR_WIDTH-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [DATA_WIDTH-1:0] pwdata,
  input  logic                  err_valid,
  input  logic [ERR_WIDTH-1:0]  err_vector,
  output logic [DATA_WIDTH-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  enabled,
  output logic                  error_report_enable
);

  logic [1:0]             control;
  logic [ERR_WIDTH-1:0]   status;
  logic [COUNT_WIDTH-1:0] resp_count;
  logic [COUNT_WIDTH-1:0] err_count;
  logic                   access;
  logic                   mapped;
  logic                   write_access;
  logic [ERR_WIDTH-1:0]   clear_mask;

  // the bus is serviced in the access phase, with no wait states.
  assign access       = psel && penable;
  assign write_access = access && pwrite;
  assign mapped       = paddr inside {REG_CONTROL, REG_STATUS, REG_RESP_COUNT, REG_ERR_COUNT};
  assign pready       = 1'b1;
  assign pslverr      = access && !mapped;

  assign clear_mask = (write_access && paddr == REG_STATUS) ? pwdata[ERR_WIDTH-1:0] : '0;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      control <= 2'b00;
    end else if (write_access && paddr == REG_CONTROL) begin
      control <= pwdata[1:0];
    end
  end

  // a new error in the same cycle as a clear stays set.
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      status <= '0;
    end else begin
      status <= (status & ~clear_mask) | (err_valid ? err_vector : '0);
    end
  end

  // both counters wrap on overflow.
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      resp_count <= '0;
      err_count  <= '0;
    end else if (err_valid) begin
      resp_count <= resp_count + 1'b1;
      if (|err_vector) begin
        err_count <= err_count + 1'b1;
      end
    end
  end

  always_comb begin
    case (paddr)
      REG_CONTROL:    prdata = {{(DATA_WIDTH - 2){1'b0}}, control};
      REG_STATUS:     prdata = {{(DATA_WIDTH - ERR_WIDTH){1'b0}}, status};
      REG_RESP_COUNT: prdata = {{(DATA_WIDTH - COUNT_WIDTH){1'b0}}, resp_count};
      REG_ERR_COUNT:  prdata = {{(DATA_WIDTH - COUNT_WIDTH){1'b0}}, err_count};
      default:        prdata = '0;
    endcase
  end

  assign enabled             = control[0];
  assign error_report_enable = control[1];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_response_path \
  -o sim_response_path

./obj_dir/sim_response_path | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "PASS: all tests" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"

/* src.f */
response_pkg.sv
resp_capture_if.sv
tag_table.sv
response_capture.sv
response_control.sv
response_status_apb.sv
response_path_top.sv
tb_response_path.sv

/* tag_table.sv */
`timescale 1ns/1ns

module tag_table import response_pkg::*; #(
  parameter int CU_ID_WIDTH = 8
) (
  input  logic                   clock,
  input  logic                   rstn,
  input  logic                   write,
  input  logic [TAG_WIDTH-1:0]   write_tag,
  input  cmd_type_t              write_type,
  input  logic [CU_ID_WIDTH-1:0] write_cu_id,
  input  logic [TAG_WIDTH-1:0]   read_tag,
  output cmd_type_t              read_type,
  output logic [CU_ID_WIDTH-1:0] read_cu_id
);

  // one entry per tag, holding what the command was and who issued it.
  cmd_type_t              type_mem  [TAG_DEPTH];
  logic [CU_ID_WIDTH-1:0] cu_id_mem [TAG_DEPTH];

  // every tag starts out as unused.
  // an entry is only replaced when its tag is issued again.
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < TAG_DEPTH; i++) begin
        type_mem[i]  <= CMD_NONE;
        cu_id_mem[i] <= '0;
      end
    end else if (write) begin
      type_mem[write_tag]  <= write_type;
      cu_id_mem[write_tag] <= write_cu_id;
    end
  end

  // the read side is combinational.
  // a lookup in the same cycle as a write to that tag still sees the old entry.
  assign read_type  = type_mem[read_tag];
  assign read_cu_id = cu_id_mem[read_tag];

endmodule

/* tb_response_path.sv */
`timescale 1ns/1ns

module tb_response_path import response_pkg::*; ();

  localparam int CYCLE_LIMIT = 20000;

  typedef struct packed {
    int         due;
    cmd_type_t  cmd_type;
    logic [7:0] cu_id;
    logic [7:0] code;
    logic [6:0] flags;
  } expect_t;

  logic        clock;
  logic        rstn;
  logic        cmd_valid;
  logic [7:0]  cmd_tag;
  cmd_type_t   cmd_type;
  logic [7:0]  cmd_cu_id;
  logic        resp_valid;
  logic [7:0]  resp_tag;
  logic        resp_tag_parity;
  logic [7:0]  resp_code;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        read_response;
  logic        write_response;
  logic        wed_response;
  logic        restart_response;
  logic        out_valid;
  logic [7:0]  out_cu_id;
  cmd_type_t   out_cmd_type;
  logic [7:0]  out_code;
  logic [6:0]  response_error;

  // reference model of the tag table, the register block and the output pipeline.
  cmd_type_t   model_type [256];
  logic [7:0]  model_cu [256];
  logic [1:0]  model_control = 2'b00;
  logic [6:0]  model_status = '0;
  logic [15:0] model_resp_count = '0;
  logic [15:0] model_err_count = '0;
  expect_t     exp_q[$];

  logic [7:0]  codes [9] = '{8'h00, 8'h01, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08, 8'h0A};
  int          cycle = 0;
  int          errors = 0;
  int          test_errors_start = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  response_path_top response_path_top_i (.*);

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle = cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic log_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // flags expected for a host code without the parity bit.
  function automatic logic [6:0] code_flags(input logic [7:0] code);
    logic [6:0] f;
    f = '0;
    case (code)
      8'h01:   f[ERR_AERROR] = 1'b1;
      8'h03:   f[ERR_DERROR] = 1'b1;
      8'h06:   f[ERR_FLUSHED] = 1'b1;
      8'h07:   f[ERR_FAULT] = 1'b1;
      8'h08:   f[ERR_FAILED] = 1'b1;
      8'h0A:   f[ERR_PAGED] = 1'b1;
      default: f = '0;
    endcase
    return f;
  endfunction

  // bit order is read, write, wed, restart.
  function automatic logic [3:0] one_hot(input cmd_type_t t);
    case (t)
      CMD_READ:    return 4'b1000;
      CMD_WRITE:   return 4'b0100;
      CMD_WED:     return 4'b0010;
      CMD_RESTART: return 4'b0001;
      default:     return 4'b0000;
    endcase
  endfunction

  task automatic check_outputs();
    expect_t    e;
    logic [6:0] shown;
    logic [3:0] hot;
    hot = {read_response, write_response, wed_response, restart_response};
    if (out_valid) begin
      assert (exp_q.size() != 0) else log_error("out_valid raised with no response pending");
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        shown = model_control[1] ? e.flags : 7'd0;
        assert (e.due == cycle)
          else log_error($sformatf("output due at cycle %0d came at cycle %0d", e.due, cycle));
        assert (hot == one_hot(e.cmd_type) && out_cmd_type == e.cmd_type)
          else log_error($sformatf("indication %b type %0d, expected type %0d",
                                   hot, out_cmd_type, e.cmd_type));
        assert (out_cu_id == e.cu_id && out_code == e.code)
          else log_error($sformatf("cu id %h code %h, expected %h %h",
                                   out_cu_id, out_code, e.cu_id, e.code));
        assert (response_error == shown)
          else log_error($sformatf("response_error %b, expected %b", response_error, shown));
      end
    end else begin
      assert (hot == 4'b0 && response_error == 7'd0)
        else log_error("indication or error raised without out_valid");
      if (exp_q.size() != 0) begin
        assert (exp_q[0].due > cycle) else begin
          log_error($sformatf("no output for the response due at cycle %0d", exp_q[0].due));
          exp_q.delete(0);
        end
      end
    end
  endtask

  // outputs are compared in the middle of the cycle, away from both edges.
  always @(negedge clock) begin
    if (rstn) begin
      check_outputs();
    end
  end

  task automatic send_command(input logic [7:0] tag, input cmd_type_t t, input logic [7:0] cu);
    cmd_valid = 1'b1;
    cmd_tag = tag;
    cmd_type = t;
    cmd_cu_id = cu;
    model_type[tag] = t;
    model_cu[tag] = cu;
    @(posedge clock);
    #1;
    cmd_valid = 1'b0;
  endtask

  // resp_valid is left high so that calls can follow each other back to back.
  task automatic send_response(input logic [7:0] tag, input logic bad_parity,
                               input logic [7:0] code);
    expect_t e;
    resp_valid = 1'b1;
    resp_tag = tag;
    resp_tag_parity = bad_parity ? ^tag : ~^tag;
    resp_code = code;
    if (model_control[0]) begin
      e.due = cycle + 2;
      e.cmd_type = model_type[tag];
      e.cu_id = model_cu[tag];
      e.code = code;
      e.flags = code_flags(code);
      e.flags[ERR_TAG_PARITY] = bad_parity;
      exp_q.push_back(e);
      model_resp_count = model_resp_count + 16'd1;
      if (e.flags != 7'd0) begin
        model_err_count = model_err_count + 16'd1;
      end
      model_status = model_status | e.flags;
    end
    @(posedge clock);
    #1;
  endtask

  task automatic idle_cycle();
    resp_valid = 1'b0;
    @(posedge clock);
    #1;
  endtask

  task automatic drain_pipeline();
    resp_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clock);
    end
    repeat (2) @(posedge clock);
    #1;
  endtask

  task automatic apb_access(input logic [11:0] addr, input logic write, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    paddr = addr;
    pwrite = write;
    pwdata = wdata;
    psel = 1'b1;
    penable = 1'b0;
    @(posedge clock);
    #1;
    penable = 1'b1;
    @(negedge clock);
    rdata = prdata;
    err = pslverr;
    assert (pready) else log_error("pready low in the access phase");
    @(posedge clock);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic write_register(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b1, data, rdata, err);
    assert (!err) else log_error($sformatf("pslverr on write to %h", addr));
    if (addr == 12'h000) begin
      model_control = data[1:0];
    end else if (addr == 12'h004) begin
      model_status = model_status & ~data[6:0];
    end
  endtask

  task automatic check_register(input logic [11:0] addr, input logic [31:0] expected);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b0, 32'd0, rdata, err);
    assert (!err && rdata == expected)
      else log_error($sformatf("register %h read %h err %b, expected %h", addr, rdata, err,
                               expected));
  endtask

  task automatic end_test(input string name);
    int n;
    n = errors - test_errors_start;
    if (n == 0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, n);
    end
    test_errors_start = errors;
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [6:0]  mask;
    void'($urandom(32'h4d3b));
    for (int i = 0; i < 256; i++) begin
      model_type[i] = CMD_NONE;
      model_cu[i] = 8'd0;
    end
    clock = 1'b0;
    rstn = 1'b0;
    cmd_valid = 1'b0;
    cmd_tag = '0;
    cmd_type = CMD_NONE;
    cmd_cu_id = '0;
    resp_valid = 1'b0;
    resp_tag = '0;
    resp_tag_parity = 1'b0;
    resp_code = '0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    repeat (16) @(posedge clock);
    #1;
    rstn = 1'b1;

    // unwritten tags of the partly filled table stay CMD_NONE.
    write_register(12'h000, 32'h3);
    for (int i = 0; i < 200; i++) begin
      send_command(8'($urandom), cmd_type_t'(3'($urandom_range(4, 0))), 8'($urandom));
    end
    for (int i = 0; i < 300; i++) begin
      send_response(8'($urandom), 1'b0, codes[$urandom_range(8, 0)]);
      if ($urandom_range(1, 0) == 1) begin
        idle_cycle();
      end
    end
    drain_pipeline();
    end_test("routing");

    for (int i = 0; i < 200; i++) begin
      send_response(8'($urandom), 1'($urandom_range(1, 0)), 8'h00);
    end
    drain_pipeline();
    end_test("parity");

    for (int i = 0; i < 9; i++) begin
      send_response(8'($urandom), 1'b0, codes[i]);
    end
    for (int i = 0; i < 40; i++) begin
      send_response(8'($urandom), 1'b0, 8'($urandom));
    end
    drain_pipeline();
    end_test("code decode");

    // the disabled path drops everything and the burst after it sends one response per cycle.
    write_register(12'h000, 32'h2);
    for (int i = 0; i < 50; i++) begin
      send_response(8'($urandom), 1'($urandom_range(1, 0)), codes[$urandom_range(8, 0)]);
    end
    drain_pipeline();
    check_register(12'h008, {16'd0, model_resp_count});
    check_register(12'h00C, {16'd0, model_err_count});
    write_register(12'h000, 32'h3);
    for (int i = 0; i < 64; i++) begin
      send_response(8'($urandom), 1'($urandom_range(1, 0)), codes[$urandom_range(8, 0)]);
    end
    drain_pipeline();
    end_test("enable");

    check_register(12'h008, {16'd0, model_resp_count});
    check_register(12'h00C, {16'd0, model_err_count});
    check_register(12'h004, {25'd0, model_status});
    mask = 7'($urandom);
    write_register(12'h004, {25'd0, mask});
    check_register(12'h004, {25'd0, model_status});
    apb_access(12'h010, 1'b0, 32'd0, rdata, err);
    assert (err) else log_error("read of offset 010 gave no pslverr");
    apb_access(12'h010, 1'b1, 32'h0, rdata, err);
    assert (err) else log_error("write to offset 010 gave no pslverr");
    check_register(12'h000, {30'd0, model_control});
    end_test("register access");

    // errors are still recorded while the response_error port is masked.
    write_register(12'h000, 32'h1);
    write_register(12'h004, 32'h7F);
    send_response(8'($urandom), 1'b1, 8'h07);
    for (int i = 0; i < 60; i++) begin
      send_response(8'($urandom), 1'($urandom_range(1, 0)), codes[$urandom_range(8, 0)]);
    end
    drain_pipeline();
    check_register(12'h004, {25'd0, model_status});
    check_register(12'h00C, {16'd0, model_err_count});
    check_register(12'h008, {16'd0, model_resp_count});
    end_test("error reporting enable");

    $display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_passed, tests_failed,
             errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
